//--- list.f
+incdir+include
rtl/nes_cart_pkg.sv
rtl/boot_loader.sv
rtl/mapper_banks.sv
rtl/cart_memory.sv
rtl/nes_cart_top.sv
tb/nes_cart_assert.sv
tb/nes_cart_tb.sv

//--- run.sh
#!/bin/sh
# Builds the cartridge testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module nes_cart_tb -Mdir obj_dir -o nes_cart_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/nes_cart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- tb/nes_cart_tb.sv
// Cartridge core testbench: random games are streamed in and read back against a model

`timescale 1ns/1ns
`default_nettype none

`include "nes_cart_params.svh"

module nes_cart_tb;

    localparam int NUM_GAMES = 6;
    localparam int ROUNDS    = 32;              // Bus rounds per game, 7 cycles each
    localparam int PHASE_LEN = 8 + ROUNDS * 7;  // Reset and bus phase of one game

    logic                  clk_i;
    logic                  reset_i;
    logic                  boot_valid_i;
    logic [`DATA_W-1:0]    boot_data_i;
    logic                  boot_ready_o;
    logic                  boot_complete_o;
    logic                  mapper_wr_i;
    logic [`CPU_AW-1:0]    mapper_addr_i;
    logic [`DATA_W-1:0]    mapper_wr_data_i;
    logic                  prg_rd_i;
    logic [`CPU_AW-1:0]    prg_addr_i;
    logic                  ram_rd_i;
    logic                  ram_wr_i;
    logic [`PRG_RAM_AW-1:0] ram_addr_i;
    logic [`DATA_W-1:0]    ram_wr_data_i;
    logic                  chr_rd_i;
    logic                  chr_wr_i;
    logic [`PPU_AW-1:0]    chr_addr_i;
    logic [`DATA_W-1:0]    chr_wr_data_i;
    logic [`DATA_W-1:0]    prg_rom_rd_data_o;
    logic [`DATA_W-1:0]    prg_ram_rd_data_o;
    logic [`DATA_W-1:0]    chr_rd_data_o;
    nes_cart_pkg::layout_e nametable_layout_o;

    // Reference memories, kept across games like the cartridge memories
    logic [`DATA_W-1:0] prg_model [0:(1 << `PRG_ROM_AW) - 1];
    logic [`DATA_W-1:0] chr_model [0:(1 << `CHR_AW) - 1];
    logic [`DATA_W-1:0] ram_model [0:(1 << `PRG_RAM_AW) - 1];
    bit                 chr_known [0:(1 << `CHR_AW) - 1];  // Loaded or written at least once
    bit                 ram_known [0:(1 << `PRG_RAM_AW) - 1];  // Written under a supported board

    logic [`PRG_RAM_AW-1:0] ram_addrs [ROUNDS];

    int         game_prg [NUM_GAMES];
    int         game_chr [NUM_GAMES];
    logic [7:0] game_map [NUM_GAMES];
    bit         game_vert [NUM_GAMES];
    int         cur_prg;
    int         cur_chr;
    logic [7:0] cur_map;
    bit         cur_vert;
    int         ux_bank;
    int         cn_bank;
    int         ax_bank;
    bit         ax_screen;
    integer     seed = 32'hb369edfc;
    int         cycles = 0;
    int         limit = 0;

    nes_cart_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            stop_run($sformatf("Timeout: the run did not finish within %0d clock cycles", limit));
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_byte(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            stop_run($sformatf("ERROR at %0t ns: %s read %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_layout(input nes_cart_pkg::layout_e got,
                                input nes_cart_pkg::layout_e exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("ERROR at %0t ns: %s is %s, expected %s", $time, what,
                               got.name(), exp.name()));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Advance to the next falling edge and drop all one-cycle strobes
    task automatic next_cycle();
        @(negedge clk_i);
        boot_valid_i = 1'b0;
        mapper_wr_i  = 1'b0;
        prg_rd_i     = 1'b0;
        ram_rd_i     = 1'b0;
        ram_wr_i     = 1'b0;
        chr_rd_i     = 1'b0;
        chr_wr_i     = 1'b0;
    endtask

    function automatic logic [7:0] mapper_code(input int sel);
        case (sel)
            0:       return 8'd0;
            1:       return 8'd2;
            2:       return 8'd3;
            3:       return 8'd7;
            default: return 8'd1;  // MMC1, not handled by this core
        endcase
    endfunction

    function automatic int prg_index(input int cpu);
        int idx;
        case (cur_map)
            nes_cart_pkg::MAP_NROM,
            nes_cart_pkg::MAP_CNROM: idx = cpu;
            nes_cart_pkg::MAP_UXROM: begin
                idx = (((cpu >> 14) & 1) != 0 ? cur_prg - 1 : ux_bank) * 16384 + (cpu & 16383);
            end
            nes_cart_pkg::MAP_AXROM: idx = ax_bank * 32768 + cpu;
            default:                 idx = 0;
        endcase
        return idx & (cur_prg * 16384 - 1);
    endfunction

    function automatic int chr_index(input int ppu);
        int idx;
        int mask;
        mask = (cur_chr == 0) ? 8191 : cur_chr * 8192 - 1;  // CHR RAM is one 8 KB bank
        case (cur_map)
            nes_cart_pkg::MAP_NROM,
            nes_cart_pkg::MAP_UXROM,
            nes_cart_pkg::MAP_AXROM: idx = ppu;
            nes_cart_pkg::MAP_CNROM: idx = cn_bank * 8192 + ppu;
            default:                 idx = 0;
        endcase
        return idx & mask;
    endfunction

    function automatic nes_cart_pkg::layout_e expected_layout();
        if (cur_map == nes_cart_pkg::MAP_AXROM) begin
            return ax_screen ? nes_cart_pkg::LAYOUT_SINGLE_HIGH : nes_cart_pkg::LAYOUT_SINGLE_LOW;
        end
        return cur_vert ? nes_cart_pkg::LAYOUT_VERTICAL : nes_cart_pkg::LAYOUT_HORIZONTAL;
    endfunction

    task automatic update_banks(input logic [`DATA_W-1:0] d);
        case (cur_map)
            nes_cart_pkg::MAP_UXROM: ux_bank = int'(d[1:0]);  // Four PRG banks at most
            nes_cart_pkg::MAP_CNROM: cn_bank = int'(d[1:0]);
            nes_cart_pkg::MAP_AXROM: begin
                ax_bank   = int'(d[2:0]);
                ax_screen = d[4];
            end
            default: ;
        endcase
    endtask

    task automatic apply_reset();
        reset_i = 1'b1;
        repeat (5) @(negedge clk_i);
        reset_i   = 1'b0;
        ux_bank   = 0;
        cn_bank   = 0;
        ax_bank   = 0;
        ax_screen = 1'b0;
    endtask

    // One byte with a random number of idle cycles in front of it
    task automatic send_byte(input logic [`DATA_W-1:0] b);
        while (($random(seed) & 7) == 0) begin
            next_cycle();
        end
        check_flag(boot_ready_o, 1'b1, "boot_ready_o before the last byte");
        boot_valid_i = 1'b1;
        boot_data_i  = b;
        next_cycle();
    endtask

    task automatic load_game(input int g);
        logic [`DATA_W-1:0] b;
        cur_prg  = game_prg[g];
        cur_chr  = game_chr[g];
        cur_map  = game_map[g];
        cur_vert = game_vert[g];
        send_byte(8'(cur_prg));
        send_byte(8'(cur_chr));
        send_byte(cur_map);
        send_byte({7'd0, cur_vert});
        for (int i = 0; i < cur_prg * 16384; i++) begin
            b = 8'($random(seed));
            prg_model[i] = b;
            send_byte(b);
        end
        for (int i = 0; i < cur_chr * 8192; i++) begin
            b = 8'($random(seed));
            chr_model[i] = b;
            chr_known[i] = 1'b1;
            send_byte(b);
        end
        check_flag(boot_complete_o, 1'b1, "boot_complete_o after the last byte");
        check_flag(boot_ready_o, 1'b0, "boot_ready_o after the last byte");
    endtask

    task automatic run_bus_rounds();
        logic [`CPU_AW-1:0]     cpu;
        logic [`PPU_AW-1:0]     ppu;
        logic [`PRG_RAM_AW-1:0] ra;
        logic [`DATA_W-1:0]     d;
        bit                     sup;
        int                     idx;
        sup = (cur_map == 8'd0) || (cur_map == 8'd2) || (cur_map == 8'd3) || (cur_map == 8'd7);
        if (sup) check_layout(nametable_layout_o, expected_layout(), "layout after load");
        for (int r = 0; r < ROUNDS; r++) begin
            d                = 8'($random(seed));
            mapper_wr_i      = 1'b1;
            mapper_addr_i    = 15'($random(seed));
            mapper_wr_data_i = d;
            next_cycle();
            update_banks(d);
            if (sup) check_layout(nametable_layout_o, expected_layout(), "layout after write");

            cpu        = 15'($random(seed));
            prg_rd_i   = 1'b1;
            prg_addr_i = cpu;
            next_cycle();
            check_byte(prg_rom_rd_data_o, prg_model[prg_index(int'(cpu))], "PRG ROM");

            // Contents left by earlier games, including writes an unsupported board dropped
            ra         = ram_addrs[r];
            ram_rd_i   = 1'b1;
            ram_addr_i = ra;
            next_cycle();
            if (!sup) begin
                check_byte(prg_ram_rd_data_o, 8'h00, "PRG RAM before write");
            end else if (ram_known[ra]) begin
                check_byte(prg_ram_rd_data_o, ram_model[ra], "PRG RAM before write");
            end

            d             = 8'($random(seed));
            ram_wr_i      = 1'b1;
            ram_wr_data_i = d;
            next_cycle();
            if (sup) begin
                ram_model[ra] = d;
                ram_known[ra] = 1'b1;
            end
            ram_rd_i = 1'b1;
            next_cycle();
            // Unsupported boards keep the read data cleared by the load
            check_byte(prg_ram_rd_data_o, sup ? ram_model[ra] : 8'h00, "PRG RAM");

            ppu           = 13'($random(seed));
            d             = 8'($random(seed));
            chr_wr_i      = 1'b1;
            chr_addr_i    = ppu;
            chr_wr_data_i = d;
            next_cycle();
            idx = chr_index(int'(ppu));
            if (sup && cur_chr == 0) begin
                chr_model[idx] = d;
                chr_known[idx] = 1'b1;
            end
            chr_rd_i = 1'b1;
            next_cycle();
            if (chr_known[idx]) check_byte(chr_rd_data_o, chr_model[idx], "CHR");
        end
    endtask

    initial begin
        int total;
        reset_i          = 1'b1;
        boot_valid_i     = 1'b0;
        boot_data_i      = '0;
        mapper_wr_i      = 1'b0;
        mapper_addr_i    = '0;
        mapper_wr_data_i = '0;
        prg_rd_i         = 1'b0;
        prg_addr_i       = '0;
        ram_rd_i         = 1'b0;
        ram_wr_i         = 1'b0;
        ram_addr_i       = '0;
        ram_wr_data_i    = '0;
        chr_rd_i         = 1'b0;
        chr_wr_i         = 1'b0;
        chr_addr_i       = '0;
        chr_wr_data_i    = '0;
        total            = 0;
        // Mapper and CHR count rotate so every board sees CHR RAM or CHR ROM
        for (int g = 0; g < NUM_GAMES; g++) begin
            game_map[g]  = mapper_code(g % 5);
            game_prg[g]  = 1 + ($random(seed) & 1);
            game_chr[g]  = g % 3;
            game_vert[g] = 1'($random(seed));
            total += `HEADER_BYTES + 16384 * game_prg[g] + 8192 * game_chr[g] + PHASE_LEN;
        end
        // Every game works on the same PRG RAM addresses, so contents carry over
        for (int r = 0; r < ROUNDS; r++) begin
            ram_addrs[r] = 13'($random(seed));
        end
        limit = total * 3 / 2;
        for (int g = 0; g < NUM_GAMES; g++) begin
            apply_reset();
            load_game(g);
            run_bus_rounds();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/nes_cart_assert.sv
// Loader handshake checks, bound into the cartridge top level

`timescale 1ns/1ns
`default_nettype none

module nes_cart_assert (
    input wire clk_i,
    input wire reset_i,
    input wire boot_valid_i,
    input wire boot_ready_i,
    input wire boot_complete_i
);

    // A finished load offers no more ready
    ready_low_when_done: assert property (@(posedge clk_i) boot_complete_i |-> !boot_ready_i)
        else $error("boot_ready_o is high while boot_complete_o is high");

    complete_holds: assert property (@(posedge clk_i)
        $past(boot_complete_i) && !$past(reset_i) |-> boot_complete_i)
        else $error("boot_complete_o fell without a reset");

    no_byte_after_done: assert property (@(posedge clk_i)
        boot_complete_i |-> !(boot_valid_i && boot_ready_i))
        else $error("A boot byte was accepted after completion");

endmodule

bind nes_cart_top nes_cart_assert assert_i (
    .clk_i           (clk_i          ),
    .reset_i         (reset_i        ),
    .boot_valid_i    (boot_valid_i   ),
    .boot_ready_i    (boot_ready_o   ),
    .boot_complete_i (boot_complete_o)
);

`default_nettype wire

//--- rtl/nes_cart_top.sv
// Cartridge core top: game loader, bank mappers and the three on-board memories

`timescale 1ns/1ns
`default_nettype none

`include "nes_cart_params.svh"

module nes_cart_top (
    input  wire                    clk_i,
    input  wire                    reset_i,
    input  wire                    boot_valid_i,
    input  wire [`DATA_W-1:0]      boot_data_i,
    output logic                   boot_ready_o,
    output logic                   boot_complete_o,
    input  wire                    mapper_wr_i,
    input  wire [`CPU_AW-1:0]      mapper_addr_i,
    input  wire [`DATA_W-1:0]      mapper_wr_data_i,
    input  wire                    prg_rd_i,
    input  wire [`CPU_AW-1:0]      prg_addr_i,
    input  wire                    ram_rd_i,
    input  wire                    ram_wr_i,
    input  wire [`PRG_RAM_AW-1:0]  ram_addr_i,
    input  wire [`DATA_W-1:0]      ram_wr_data_i,
    input  wire                    chr_rd_i,
    input  wire                    chr_wr_i,
    input  wire [`PPU_AW-1:0]      chr_addr_i,
    input  wire [`DATA_W-1:0]      chr_wr_data_i,
    output logic [`DATA_W-1:0]     prg_rom_rd_data_o,
    output logic [`DATA_W-1:0]     prg_ram_rd_data_o,
    output logic [`DATA_W-1:0]     chr_rd_data_o,
    output nes_cart_pkg::layout_e  nametable_layout_o
);

    localparam nes_cart_pkg::mem_req_t NO_REQ = '0;  // PRG RAM is never loaded

    nes_cart_pkg::cart_header_t header;
    nes_cart_pkg::mem_req_t     prg_boot_wr;
    nes_cart_pkg::mem_req_t     chr_boot_wr;
    nes_cart_pkg::mem_req_t     prg_rom_req;
    nes_cart_pkg::mem_req_t     prg_ram_req;
    nes_cart_pkg::mem_req_t     chr_req;
    logic                       booting;

    boot_loader
        boot_loader
        (
            .clk_i              (clk_i             ),
            .reset_i            (reset_i           ),
            .boot_valid_i       (boot_valid_i      ),
            .boot_data_i        (boot_data_i       ),
            .boot_ready_o       (boot_ready_o      ),
            .boot_complete_o    (boot_complete_o   ),
            .header_o           (header            ),
            .booting_o          (booting           ),
            .prg_wr_o           (prg_boot_wr       ),
            .chr_wr_o           (chr_boot_wr       )
        );

    mapper_banks
        mapper_banks
        (
            .clk_i              (clk_i             ),
            .reset_i            (reset_i           ),
            .header_i           (header            ),
            .booting_i          (booting           ),
            .mapper_wr_i        (mapper_wr_i       ),
            .mapper_addr_i      (mapper_addr_i     ),
            .mapper_wr_data_i   (mapper_wr_data_i  ),
            .prg_rd_i           (prg_rd_i          ),
            .prg_addr_i         (prg_addr_i        ),
            .ram_rd_i           (ram_rd_i          ),
            .ram_wr_i           (ram_wr_i          ),
            .ram_addr_i         (ram_addr_i        ),
            .ram_wr_data_i      (ram_wr_data_i     ),
            .chr_rd_i           (chr_rd_i          ),
            .chr_wr_i           (chr_wr_i          ),
            .chr_addr_i         (chr_addr_i        ),
            .chr_wr_data_i      (chr_wr_data_i     ),
            .prg_rom_req_o      (prg_rom_req       ),
            .prg_ram_req_o      (prg_ram_req       ),
            .chr_req_o          (chr_req           ),
            .nametable_layout_o (nametable_layout_o)
        );

    cart_memory #(.DEPTH_AW(`PRG_ROM_AW))
        prg_rom
        (
            .clk_i              (clk_i             ),
            .booting_i          (booting           ),
            .boot_req_i         (prg_boot_wr       ),
            .bus_req_i          (prg_rom_req       ),
            .rd_data_o          (prg_rom_rd_data_o )
        );

    cart_memory #(.DEPTH_AW(`PRG_RAM_AW))
        prg_ram
        (
            .clk_i              (clk_i             ),
            .booting_i          (booting           ),
            .boot_req_i         (NO_REQ            ),
            .bus_req_i          (prg_ram_req       ),
            .rd_data_o          (prg_ram_rd_data_o )
        );

    cart_memory #(.DEPTH_AW(`CHR_AW))
        chr_mem
        (
            .clk_i              (clk_i             ),
            .booting_i          (booting           ),
            .boot_req_i         (chr_boot_wr       ),
            .bus_req_i          (chr_req           ),
            .rd_data_o          (chr_rd_data_o     )
        );

endmodule

`default_nettype wire

//--- rtl/cart_memory.sv
// Byte-wide single-port cartridge memory shared between the loader and the bus

`timescale 1ns/1ns
`default_nettype none

`include "nes_cart_params.svh"

module cart_memory #(
    parameter int DEPTH_AW = 13
) (
    input  wire                         clk_i,
    input  wire                         booting_i,
    input  wire nes_cart_pkg::mem_req_t boot_req_i,
    input  wire nes_cart_pkg::mem_req_t bus_req_i,
    output logic [`DATA_W-1:0]          rd_data_o
);

    logic [`DATA_W-1:0]     mem [0:(1 << DEPTH_AW) - 1];
    nes_cart_pkg::mem_req_t req;
    logic [DEPTH_AW-1:0]    addr;

    // Loader owns the port until the game is in place
    assign req  = booting_i ? boot_req_i : bus_req_i;
    assign addr = req.addr[DEPTH_AW-1:0];

    always_ff @(posedge clk_i) begin
        if (req.wr) begin
            mem[addr] <= req.wdata;
        end
    end

    // Read data holds between reads and is cleared during the load
    always_ff @(posedge clk_i) begin
        if (booting_i) begin
            rd_data_o <= '0;
        end else if (req.rd) begin
            rd_data_o <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/mapper_banks.sv
// Bank registers and address translation for NROM, UxROM, CNROM and AxROM boards

`timescale 1ns/1ns
`default_nettype none

`include "nes_cart_params.svh"

module mapper_banks (
    input  wire                              clk_i,
    input  wire                              reset_i,
    input  wire nes_cart_pkg::cart_header_t  header_i,
    input  wire                              booting_i,
    input  wire                              mapper_wr_i,
    input  wire [`CPU_AW-1:0]                mapper_addr_i,
    input  wire [`DATA_W-1:0]                mapper_wr_data_i,
    input  wire                              prg_rd_i,
    input  wire [`CPU_AW-1:0]                prg_addr_i,
    input  wire                              ram_rd_i,
    input  wire                              ram_wr_i,
    input  wire [`PRG_RAM_AW-1:0]            ram_addr_i,
    input  wire [`DATA_W-1:0]                ram_wr_data_i,
    input  wire                              chr_rd_i,
    input  wire                              chr_wr_i,
    input  wire [`PPU_AW-1:0]                chr_addr_i,
    input  wire [`DATA_W-1:0]                chr_wr_data_i,
    output nes_cart_pkg::mem_req_t           prg_rom_req_o,
    output nes_cart_pkg::mem_req_t           prg_ram_req_o,
    output nes_cart_pkg::mem_req_t           chr_req_o,
    output nes_cart_pkg::layout_e            nametable_layout_o
);

    localparam int PRG_SEL_W = `PRG_ROM_AW - `PRG_BANK_AW;  // 16 KB bank select
    localparam int CHR_SEL_W = `CHR_AW - `CHR_BANK_AW;      // 8 KB bank select
    localparam int AX_SEL_W  = `PRG_ROM_AW - `CPU_AW;       // 32 KB bank select

    logic [PRG_SEL_W-1:0]   uxrom_bank;
    logic [CHR_SEL_W-1:0]   cnrom_bank;
    logic [AX_SEL_W-1:0]    axrom_bank;
    logic                   axrom_screen;
    logic [PRG_SEL_W-1:0]   prg_last_bank;
    logic [CHR_SEL_W-1:0]   chr_last_bank;
    logic [`PRG_ROM_AW-1:0] prg_map;
    logic [`PRG_ROM_AW-1:0] prg_mask;
    logic [`CHR_AW-1:0]     chr_map;
    logic [`CHR_AW-1:0]     chr_mask;
    logic [`PRG_RAM_AW-1:0] ram_map;
    logic                   supported;
    logic                   chr_ram;
    logic                   bus_on;

    assign supported = (header_i.mapper inside {nes_cart_pkg::MAP_NROM, nes_cart_pkg::MAP_UXROM,
                                                nes_cart_pkg::MAP_CNROM, nes_cart_pkg::MAP_AXROM});
    assign chr_ram   = (header_i.chr_banks == 3'd0);
    assign bus_on    = !booting_i;

    // Bank counts are powers of two, so the last bank doubles as the mask
    assign prg_last_bank = PRG_SEL_W'(header_i.prg_banks - 3'd1);
    assign chr_last_bank = chr_ram ? '0 : CHR_SEL_W'(header_i.chr_banks - 3'd1);
    assign prg_mask      = {prg_last_bank, {`PRG_BANK_AW{1'b1}}};
    assign chr_mask      = {chr_last_bank, {`CHR_BANK_AW{1'b1}}};

    // Every write in the window hits the single register of these boards
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            uxrom_bank   <= '0;
            cnrom_bank   <= '0;
            axrom_bank   <= '0;
            axrom_screen <= 1'b0;
        end else if (mapper_wr_i && bus_on) begin
            case (header_i.mapper)
                nes_cart_pkg::MAP_UXROM: uxrom_bank <= mapper_wr_data_i[PRG_SEL_W-1:0];
                nes_cart_pkg::MAP_CNROM: cnrom_bank <= mapper_wr_data_i[CHR_SEL_W-1:0];
                nes_cart_pkg::MAP_AXROM: begin
                    axrom_bank   <= mapper_wr_data_i[AX_SEL_W-1:0];  // Bits 2:1 exceed 64 KB
                    axrom_screen <= mapper_wr_data_i[4];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        prg_map            = {{AX_SEL_W{1'b0}}, prg_addr_i};
        chr_map            = {{CHR_SEL_W{1'b0}}, chr_addr_i};
        ram_map            = ram_addr_i;
        nametable_layout_o = header_i.vertical ? nes_cart_pkg::LAYOUT_VERTICAL
                                               : nes_cart_pkg::LAYOUT_HORIZONTAL;
        case (header_i.mapper)
            nes_cart_pkg::MAP_NROM: ;
            nes_cart_pkg::MAP_UXROM: begin
                // Upper 16 KB window is fixed to the last bank
                prg_map = {prg_addr_i[`PRG_BANK_AW] ? prg_last_bank : uxrom_bank,
                           prg_addr_i[`PRG_BANK_AW-1:0]};
            end
            nes_cart_pkg::MAP_CNROM: chr_map = {cnrom_bank, chr_addr_i};
            nes_cart_pkg::MAP_AXROM: begin
                prg_map            = {axrom_bank, prg_addr_i};
                nametable_layout_o = axrom_screen ? nes_cart_pkg::LAYOUT_SINGLE_HIGH
                                                  : nes_cart_pkg::LAYOUT_SINGLE_LOW;
            end
            default: begin
                prg_map            = '0;
                chr_map            = '0;
                ram_map            = '0;
                nametable_layout_o = nes_cart_pkg::LAYOUT_HORIZONTAL;
            end
        endcase
    end

    always_comb begin
        prg_rom_req_o.rd    = prg_rd_i && bus_on;
        prg_rom_req_o.wr    = 1'b0;                    // Read only
        prg_rom_req_o.addr  = prg_map & prg_mask;
        prg_rom_req_o.wdata = '0;

        prg_ram_req_o.rd    = ram_rd_i && bus_on && supported;
        prg_ram_req_o.wr    = ram_wr_i && bus_on && supported;
        prg_ram_req_o.addr  = {{(`PRG_ROM_AW - `PRG_RAM_AW){1'b0}}, ram_map};
        prg_ram_req_o.wdata = ram_wr_data_i;

        chr_req_o.rd        = chr_rd_i && bus_on;
        chr_req_o.wr        = chr_wr_i && bus_on && supported && chr_ram;  // CHR ROM ignores writes
        chr_req_o.addr      = {{(`PRG_ROM_AW - `CHR_AW){1'b0}}, chr_map & chr_mask};
        chr_req_o.wdata     = chr_wr_data_i;
    end

endmodule

`default_nettype wire

//--- rtl/boot_loader.sv
// Game loader: parses the stream header and writes the PRG and CHR images into memory

`timescale 1ns/1ns
`default_nettype none

`include "nes_cart_params.svh"

module boot_loader (
    input  wire                         clk_i,
    input  wire                         reset_i,
    input  wire                         boot_valid_i,
    input  wire [`DATA_W-1:0]           boot_data_i,
    output logic                        boot_ready_o,
    output logic                        boot_complete_o,
    output nes_cart_pkg::cart_header_t  header_o,
    output logic                        booting_o,
    output nes_cart_pkg::mem_req_t      prg_wr_o,
    output nes_cart_pkg::mem_req_t      chr_wr_o
);

    nes_cart_pkg::boot_state_e state;
    logic [`PRG_ROM_AW-1:0]    count;     // Byte index inside the current phase
    logic [`PRG_ROM_AW-1:0]    prg_last;
    logic [`PRG_ROM_AW-1:0]    chr_last;
    logic                      accept;
    logic                      last_byte;

    assign accept = boot_valid_i && boot_ready_o;

    // Last image address of each phase, from the bank counts
    assign prg_last = `PRG_ROM_AW'({header_o.prg_banks, {`PRG_BANK_AW{1'b0}}} - 1'b1);
    assign chr_last = `PRG_ROM_AW'({header_o.chr_banks, {`CHR_BANK_AW{1'b0}}} - 1'b1);

    always_comb begin
        case (state)
            nes_cart_pkg::BOOT_HEADER: last_byte = (count == `PRG_ROM_AW'(`HEADER_BYTES - 1));
            nes_cart_pkg::BOOT_PRG:    last_byte = (count == prg_last);
            nes_cart_pkg::BOOT_CHR:    last_byte = (count == chr_last);
            default:                   last_byte = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state    <= nes_cart_pkg::BOOT_HEADER;
            count    <= '0;
            header_o <= '0;
        end else if (accept) begin
            count <= last_byte ? '0 : count + 1'b1;

            if (state == nes_cart_pkg::BOOT_HEADER) begin
                case (count[1:0])
                    2'd0:    header_o.prg_banks <= boot_data_i[2:0];
                    2'd1:    header_o.chr_banks <= boot_data_i[2:0];
                    2'd2:    header_o.mapper    <= nes_cart_pkg::mapper_e'(boot_data_i);
                    default: header_o.vertical  <= boot_data_i[0];
                endcase
            end

            if (last_byte) begin
                case (state)
                    nes_cart_pkg::BOOT_HEADER: state <= nes_cart_pkg::BOOT_PRG;
                    nes_cart_pkg::BOOT_PRG: begin
                        // No CHR image when the board carries CHR RAM
                        state <= (header_o.chr_banks == 3'd0) ? nes_cart_pkg::BOOT_DONE
                                                              : nes_cart_pkg::BOOT_CHR;
                    end
                    default: state <= nes_cart_pkg::BOOT_DONE;
                endcase
            end
        end
    end

    assign boot_ready_o    = (state != nes_cart_pkg::BOOT_DONE);
    assign booting_o       = (state != nes_cart_pkg::BOOT_DONE);
    assign boot_complete_o = (state == nes_cart_pkg::BOOT_DONE);

    // Image bytes are written in the cycle they are accepted
    always_comb begin
        prg_wr_o       = '0;
        prg_wr_o.wr    = accept && (state == nes_cart_pkg::BOOT_PRG);
        prg_wr_o.addr  = count;
        prg_wr_o.wdata = boot_data_i;

        chr_wr_o       = '0;
        chr_wr_o.wr    = accept && (state == nes_cart_pkg::BOOT_CHR);
        chr_wr_o.addr  = count;
        chr_wr_o.wdata = boot_data_i;
    end

endmodule

`default_nettype wire

//--- rtl/nes_cart_pkg.sv
// Cartridge core types: mapper and layout codes, loader states and memory requests

`default_nettype none

`include "nes_cart_params.svh"

package nes_cart_pkg;

    // iNES mapper numbers handled by the core
    typedef enum logic [7:0] {
        MAP_NROM  = 8'd0,
        MAP_UXROM = 8'd2,
        MAP_CNROM = 8'd3,
        MAP_AXROM = 8'd7
    } mapper_e;

    // Nametable arrangement reported to the PPU
    typedef enum logic [2:0] {
        LAYOUT_HORIZONTAL  = 3'd0,
        LAYOUT_VERTICAL    = 3'd1,
        LAYOUT_SINGLE_LOW  = 3'd2,
        LAYOUT_SINGLE_HIGH = 3'd3
    } layout_e;

    typedef enum logic [1:0] {
        BOOT_HEADER,
        BOOT_PRG,
        BOOT_CHR,
        BOOT_DONE
    } boot_state_e;

    typedef struct packed {
        logic [2:0] prg_banks;  // 16 KB units, power of two
        logic [2:0] chr_banks;  // 8 KB units, 0 means CHR RAM
        mapper_e    mapper;
        logic       vertical;   // Mirroring flag from the header
    } cart_header_t;

    // One access to a cartridge memory; narrower memories take the low address bits
    typedef struct packed {
        logic                   rd;
        logic                   wr;
        logic [`PRG_ROM_AW-1:0] addr;
        logic [`DATA_W-1:0]     wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- include/nes_cart_params.svh
// Cartridge core parameters: bus widths, bank sizes and game header length

`ifndef NES_CART_PARAMS_SVH
`define NES_CART_PARAMS_SVH

// Data bus
`define DATA_W       8

// CPU and PPU buses as seen by the cartridge
`define CPU_AW       15   // $8000-$FFFF window
`define PPU_AW       13   // Pattern tables, $0000-$1FFF

// Bank geometry
`define PRG_BANK_AW  14   // 16 KB PRG bank
`define CHR_BANK_AW  13   // 8 KB CHR bank

// On-cartridge memories
`define PRG_ROM_AW   16   // Up to 4 PRG banks
`define CHR_AW       15   // Up to 4 CHR banks
`define PRG_RAM_AW   13   // 8 KB work RAM

// Game stream layout
`define HEADER_BYTES 4    // PRG count, CHR count, mapper, mirroring

`endif
